//--- flist.f
+incdir+hdl
hdl/itlb_pkg.sv
hdl/itlb_lookup_ctrl.sv
hdl/itlb_set_array.sv
hdl/itlb_way_match.sv
hdl/itlb_resp_miss.sv
hdl/itlb_top.sv
dv/itlb_properties.sv
dv/itlb_tb.sv

//--- dv/itlb_vectors.txt
# op(0 lookup, 1 sfence) asid vpn exec_mode l2_pte l2_access_fault
# expected: miss ppn page_fault access_fault
0 001 00010 0 0100045B 0 1 04001 0 0
0 001 00010 0 0100045B 0 0 04001 0 0
0 001 00020 0 0100087B 0 1 04002 0 0
0 011 00020 0 0100087B 0 0 04002 0 0
0 011 00010 0 01000C5B 0 1 04003 0 0
0 002 00100 0 0100105A 0 1 04004 1 0
0 002 00200 0 01001453 0 1 04005 1 0
0 002 00300 0 0100185D 0 1 04006 1 0
0 002 00400 0 01001C4B 0 1 04007 1 0
0 002 00400 1 01001C4B 0 0 04007 0 0
0 003 00100 0 0100205A 1 1 04008 0 1
1 001 00010 0 00000000 0 0 00000 0 0
0 001 00010 0 0100045B 0 1 04001 0 0
0 011 00010 0 01000C5B 0 0 04003 0 0
0 001 00020 0 0100087B 0 0 04002 0 0
1 000 00000 0 00000000 0 0 00000 0 0
0 001 00010 0 0100045B 0 1 04001 0 0
0 011 00020 0 0100087B 0 1 04002 0 0
0 002 00400 1 01001C4B 0 1 04007 0 0
0 00A 01000 0 0100245B 0 1 04009 0 0
0 00A 02000 0 0100285B 0 1 0400A 0 0
0 00A 03000 0 01002C5B 0 1 0400B 0 0
0 00A 04000 0 0100305B 0 1 0400C 0 0
0 00A 01000 0 0100245B 0 0 04009 0 0
0 00A 05000 0 0100345B 0 1 0400D 0 0
0 00A 01000 0 0100245B 0 0 04009 0 0
0 00A 02000 0 0100285B 0 0 0400A 0 0
0 00A 04000 0 0100305B 0 0 0400C 0 0
0 00A 03000 0 01002C5B 0 1 0400B 0 0

//--- dv/itlb_tb.sv
// testbench of the instruction TLB that replays dv/itlb_vectors.txt against an L2 TLB model
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_tb import itlb_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic                    CLK;
    logic                    nRST;
    logic                    core_req_valid;
    exec_mode_e              core_req_exec_mode;
    logic [`ITLB_ASID_W-1:0] core_req_asid;
    logic [`ITLB_VPN_W-1:0]  core_req_vpn;
    logic                    core_resp_valid;
    logic [`ITLB_PPN_W-1:0]  core_resp_ppn;
    logic                    core_resp_page_fault;
    logic                    core_resp_access_fault;
    logic                    l2_tlb_req_valid;
    logic [`ITLB_ASID_W-1:0] l2_tlb_req_asid;
    logic [`ITLB_VPN_W-1:0]  l2_tlb_req_vpn;
    logic                    l2_tlb_req_ready = 1'b1;
    logic                    l2_tlb_resp_valid = 1'b0;
    pte_t                    l2_tlb_resp_pte;
    logic                    l2_tlb_resp_access_fault;
    logic                    sfence_inv_valid;
    logic [`ITLB_ASID_W-1:0] sfence_inv_asid;
    logic [`ITLB_VPN_W-1:0]  sfence_inv_vpn;
    logic                    sfence_inv_ready;

    // one vector line
    logic [31:0] v_op, v_asid, v_vpn, v_mode, v_pte, v_l2af, v_miss, v_ppn, v_pf, v_af;
    logic [8*256-1:0] line;
    int fd, code, vec_count, vec_errors, checks, errors;
    bit at_end, timed_out;

    // L2 model state
    logic [31:0]             lcg_state;
    logic [31:0]             draw;
    int                      stall_cnt = 0;
    int                      resp_cnt = 0;
    int                      l2_req_count = 0;
    logic [`ITLB_ASID_W-1:0] l2_seen_asid;
    logic [`ITLB_VPN_W-1:0]  l2_seen_vpn;

    itlb_top u_itlb_top (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            vec_errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // ------------------------------
    // L2 TLB model with a random stall and one response per request

    always @(posedge CLK) begin
        l2_tlb_resp_valid <= 1'b0;
        if (resp_cnt != 0) begin
            resp_cnt <= resp_cnt - 1;
            if (resp_cnt == 1) begin
                draw = lcg_next();
                l2_tlb_resp_valid <= 1'b1;
                stall_cnt         <= draw[17:16];
                l2_tlb_req_ready  <= (draw[17:16] == 2'd0);
            end
        end else if (l2_tlb_req_valid && l2_tlb_req_ready) begin
            draw = lcg_next();
            resp_cnt         <= 1 + draw[17:16];
            l2_tlb_req_ready <= 1'b0;
            l2_req_count     <= l2_req_count + 1;
            l2_seen_asid     <= l2_tlb_req_asid;
            l2_seen_vpn      <= l2_tlb_req_vpn;
        end else if (l2_tlb_req_valid && stall_cnt != 0) begin
            stall_cnt        <= stall_cnt - 1;
            l2_tlb_req_ready <= (stall_cnt == 1);
        end
    end

    // ------------------------------
    // operations

    task automatic run_lookup();
        int cycles;
        int req_before;
        req_before = l2_req_count;
        @(posedge CLK);
        core_req_valid           <= 1'b1;
        core_req_exec_mode       <= exec_mode_e'(v_mode[1:0]);
        core_req_asid            <= v_asid[`ITLB_ASID_W-1:0];
        core_req_vpn             <= v_vpn[`ITLB_VPN_W-1:0];
        l2_tlb_resp_pte          <= v_pte;
        l2_tlb_resp_access_fault <= v_l2af[0];
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!core_resp_valid && cycles < WAIT_LIMIT);
        if (!core_resp_valid) begin
            $display("no core response within %0d cycles", WAIT_LIMIT);
            errors++;
            vec_errors++;
            timed_out = 1'b1;
        end else begin
            check_value("core_resp_ppn", core_resp_ppn, v_ppn);
            check_value("core_resp_page_fault", core_resp_page_fault, v_pf);
            check_value("core_resp_access_fault", core_resp_access_fault, v_af);
            check_value("l2_tlb_req_valid", l2_req_count - req_before, v_miss);
            if (v_miss != 0) begin
                check_value("l2_tlb_req_asid", l2_seen_asid, v_asid);
                check_value("l2_tlb_req_vpn", l2_seen_vpn, v_vpn);
            end
        end
        @(posedge CLK);
        core_req_valid <= 1'b0;
        // the held request is answered only once
        @(negedge CLK);
        if (!timed_out) begin
            check_value("core_resp_valid", core_resp_valid, 32'd0);
        end
    endtask

    task automatic run_sfence();
        int cycles;
        @(posedge CLK);
        sfence_inv_valid <= 1'b1;
        sfence_inv_asid  <= v_asid[`ITLB_ASID_W-1:0];
        sfence_inv_vpn   <= v_vpn[`ITLB_VPN_W-1:0];
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!sfence_inv_ready && cycles < WAIT_LIMIT);
        @(posedge CLK);
        sfence_inv_valid <= 1'b0;
        // all-set walk keeps ready low for a few cycles
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!sfence_inv_ready && cycles < WAIT_LIMIT);
        if (!sfence_inv_ready) begin
            $display("sfence was not accepted or ready never returned");
            errors++;
            vec_errors++;
            timed_out = 1'b1;
        end else begin
            // a VPN-zero sfence steps through the remaining sets with ready low
            check_value("sfence_inv_ready low cycles", cycles - 1,
                        (v_vpn == 0) ? (`ITLB_SETS - 1) : 0);
        end
    endtask

    // ------------------------------
    // main sequence

    initial begin
        nRST                     = 1'b0;
        core_req_valid           = 1'b0;
        core_req_exec_mode       = U_MODE;
        core_req_asid            = '0;
        core_req_vpn             = '0;
        l2_tlb_resp_pte          = '0;
        l2_tlb_resp_access_fault = 1'b0;
        sfence_inv_valid         = 1'b0;
        sfence_inv_asid          = '0;
        sfence_inv_vpn           = '0;
        lcg_state                = 32'h49232019;
        fd = $fopen("dv/itlb_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file dv/itlb_vectors.txt");
            errors++;
            at_end = 1'b1;
        end
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        while (!at_end && !timed_out) begin
            code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h", v_op, v_asid, v_vpn,
                           v_mode, v_pte, v_l2af, v_miss, v_ppn, v_pf, v_af);
            if (code == 10) begin
                vec_count++;
                vec_errors = 0;
                if (v_op == 0) begin
                    run_lookup();
                end else begin
                    run_sfence();
                end
                $display("vector %0d %s asid %h vpn %h: %s", vec_count,
                         (v_op == 0) ? "lookup" : "sfence", v_asid[8:0], v_vpn[19:0],
                         (vec_errors == 0) ? "ok" : "failed");
            end else if (code < 0) begin
                at_end = 1'b1;
            end else if (code == 0) begin
                // skip the rest of a comment line
                if ($fgets(line, fd) == 0) begin
                    at_end = 1'b1;
                end
            end else begin
                $display("malformed line after vector %0d", vec_count);
                errors++;
                at_end = 1'b1;
            end
        end
        $display("vectors %0d, checks %0d, errors %0d, assertion failures %0d",
                 vec_count, checks, errors, u_itlb_top.u_properties.fail_count);
        if (errors == 0 && u_itlb_top.u_properties.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- dv/itlb_properties.sv
// port-level assertions of the instruction TLB, bound into itlb_top for simulation
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_properties (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    core_resp_valid,
    input logic                    core_resp_page_fault,
    input logic                    core_resp_access_fault,
    input logic                    l2_tlb_req_valid,
    input logic                    l2_tlb_req_ready,
    input logic [`ITLB_ASID_W-1:0] l2_tlb_req_asid,
    input logic [`ITLB_VPN_W-1:0]  l2_tlb_req_vpn,
    input logic                    sfence_inv_ready
);

    // failed assertions, summed into the final error count
    int fail_count = 0;

    // access fault masks the page fault
    a_single_fault: assert property (@(posedge CLK) disable iff (!nRST)
        core_resp_valid |-> !(core_resp_page_fault && core_resp_access_fault))
        else begin
            fail_count++;
            $error("core response carries both faults");
        end

    // ------------------------------
    // L2 miss request

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        l2_tlb_req_valid && !l2_tlb_req_ready |=>
            l2_tlb_req_valid && $stable(l2_tlb_req_asid) && $stable(l2_tlb_req_vpn))
        else begin
            fail_count++;
            $error("L2 request dropped or changed while not ready");
        end

    a_no_req_in_walk: assert property (@(posedge CLK) disable iff (!nRST)
        !sfence_inv_ready |-> !l2_tlb_req_valid)
        else begin
            fail_count++;
            $error("L2 request during the all-set sfence walk");
        end

    // ------------------------------
    // sfence walk length

    a_ready_returns: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(sfence_inv_ready) |-> ##(`ITLB_SETS - 1) sfence_inv_ready)
        else begin
            fail_count++;
            $error("sfence_inv_ready low for too long");
        end

endmodule

bind itlb_top itlb_properties u_properties (.*);

//--- hdl/itlb_top.sv
// top level of the blocking L1 instruction TLB, placed between the fetch unit and the L2 TLB
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_top import itlb_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,

    // core request, held until the response
    input  logic                    core_req_valid,
    input  exec_mode_e              core_req_exec_mode,
    input  logic [`ITLB_ASID_W-1:0] core_req_asid,
    input  logic [`ITLB_VPN_W-1:0]  core_req_vpn,

    output logic                    core_resp_valid,
    output logic [`ITLB_PPN_W-1:0]  core_resp_ppn,
    output logic                    core_resp_page_fault,
    output logic                    core_resp_access_fault,

    // L2 TLB miss path
    output logic                    l2_tlb_req_valid,
    output logic [`ITLB_ASID_W-1:0] l2_tlb_req_asid,
    output logic [`ITLB_VPN_W-1:0]  l2_tlb_req_vpn,
    input  logic                    l2_tlb_req_ready,

    input  logic                    l2_tlb_resp_valid,
    input  pte_t                    l2_tlb_resp_pte,
    input  logic                    l2_tlb_resp_access_fault,

    // sfence.vma
    input  logic                    sfence_inv_valid,
    input  logic [`ITLB_ASID_W-1:0] sfence_inv_asid,
    input  logic [`ITLB_VPN_W-1:0]  sfence_inv_vpn,
    output logic                    sfence_inv_ready
);

    // read side
    logic                     read_valid;
    logic [`ITLB_INDEX_W-1:0] read_index;
    tlb_set_t                 read_set;

    // compare stage
    logic                     stage_valid;
    exec_mode_e               stage_exec_mode;
    logic [`ITLB_ASID_W-1:0]  stage_asid;
    logic [`ITLB_VPN_W-1:0]   stage_vpn;
    logic                     inv_active;
    logic                     hit;
    tlb_entry_t               hit_entry;

    // write back
    logic                     write_valid;
    tlb_set_t                 write_set;
    logic                     fill_valid;

    // all port names match the local nets
    itlb_lookup_ctrl u_lookup_ctrl (.*);

    itlb_set_array u_set_array (.*);

    itlb_way_match u_way_match (.*);

    itlb_resp_miss u_resp_miss (.*);

endmodule

//--- hdl/itlb_resp_miss.sv
// output side of the TLB: core response with fault checks, and the single outstanding L2 miss
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_resp_miss import itlb_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    stage_valid,
    input  exec_mode_e              stage_exec_mode,
    input  logic [`ITLB_ASID_W-1:0] stage_asid,
    input  logic [`ITLB_VPN_W-1:0]  stage_vpn,
    input  logic                    hit,
    input  tlb_entry_t              hit_entry,

    output logic                    core_resp_valid,
    output logic [`ITLB_PPN_W-1:0]  core_resp_ppn,
    output logic                    core_resp_page_fault,
    output logic                    core_resp_access_fault,

    output logic                    l2_tlb_req_valid,
    output logic [`ITLB_ASID_W-1:0] l2_tlb_req_asid,
    output logic [`ITLB_VPN_W-1:0]  l2_tlb_req_vpn,
    input  logic                    l2_tlb_req_ready,
    input  logic                    l2_tlb_resp_valid,

    output logic                    fill_valid
);

    logic miss;
    logic l2_sent;

    assign miss = stage_valid & ~hit;

    // ------------------------------
    // core response

    assign core_resp_valid = stage_valid & hit;
    assign core_resp_ppn   = {hit_entry.ppn1, hit_entry.ppn0};

    // a failed page-table access masks the PTE checks
    assign core_resp_access_fault = hit_entry.pt_access_fault;
    assign core_resp_page_fault   = ~hit_entry.pt_access_fault
        & (~hit_entry.v | ~hit_entry.x | (hit_entry.w & ~hit_entry.r)
           | ((stage_exec_mode == U_MODE) & ~hit_entry.u));

    // ------------------------------
    // miss request, one at a time

    assign l2_tlb_req_valid = miss & ~l2_sent;
    assign l2_tlb_req_asid  = stage_asid;
    assign l2_tlb_req_vpn   = stage_vpn;

    // response has no tag, so it belongs to the held miss
    assign fill_valid = miss & l2_sent & l2_tlb_resp_valid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            l2_sent <= 1'b0;
        end else if (!stage_valid || fill_valid) begin
            l2_sent <= 1'b0;
        end else if (l2_tlb_req_valid && l2_tlb_req_ready) begin
            l2_sent <= 1'b1;
        end
    end

endmodule

//--- hdl/itlb_way_match.sv
// compare stage of the TLB: way hits, replacement choice, pseudo-LRU and the set written back
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_way_match import itlb_pkg::*; (
    input  tlb_set_t                read_set,
    input  logic [`ITLB_ASID_W-1:0] stage_asid,
    input  logic [`ITLB_VPN_W-1:0]  stage_vpn,
    input  logic                    stage_valid,
    input  logic                    inv_active,
    input  logic                    fill_valid,
    input  pte_t                    l2_tlb_resp_pte,
    input  logic                    l2_tlb_resp_access_fault,
    output logic                    hit,
    output tlb_entry_t              hit_entry,
    output logic                    write_valid,
    output tlb_set_t                write_set
);

    logic [`ITLB_ASSOC-1:0] valid_by_way;
    logic [`ITLB_ASSOC-1:0] hit_by_way;
    logic [`ITLB_WAY_W-1:0] hit_way;
    logic [`ITLB_WAY_W-1:0] invalid_way;
    logic [`ITLB_WAY_W-1:0] victim_way;
    logic [`ITLB_WAY_W-1:0] fill_way;
    logic [`ITLB_ASSOC-2:0] touch_plru;
    logic                   asid_wild;
    logic                   vpn_wild;

    // zero fields of an sfence match everything
    assign asid_wild = inv_active & (stage_asid == '0);
    assign vpn_wild  = inv_active & (stage_vpn == '0);

    // ------------------------------
    // tag compare

    // walk down so the lowest way wins
    always_comb begin
        hit_way     = '0;
        invalid_way = '0;
        for (int w = `ITLB_ASSOC-1; w >= 0; w--) begin
            valid_by_way[w] = read_set.entries[w].valid;
            hit_by_way[w] = read_set.entries[w].valid
                & ((read_set.entries[w].asid == stage_asid) | read_set.entries[w].g
                   | asid_wild)
                & ((read_set.entries[w].vpn == stage_vpn) | vpn_wild);
            if (!valid_by_way[w]) begin
                invalid_way = w[`ITLB_WAY_W-1:0];
            end
            if (hit_by_way[w]) begin
                hit_way = w[`ITLB_WAY_W-1:0];
            end
        end
    end

    assign hit       = |hit_by_way;
    assign hit_entry = read_set.entries[hit_way];

    // ------------------------------
    // tree pseudo-LRU
    // plru[0] picks the half holding the victim, plru[1] and plru[2] the way inside it

    always_comb begin
        victim_way = read_set.plru[0] ? {1'b1, read_set.plru[2]} : {1'b0, read_set.plru[1]};
        // point every node on the path away from the touched way
        touch_plru    = read_set.plru;
        touch_plru[0] = ~hit_way[1];
        if (hit_way[1]) begin
            touch_plru[2] = ~hit_way[0];
        end else begin
            touch_plru[1] = ~hit_way[0];
        end
    end

    assign fill_way = (&valid_by_way) ? victim_way : invalid_way;

    // ------------------------------
    // write back, fill over invalidate over touch

    always_comb begin
        write_set   = read_set;
        write_valid = 1'b0;
        if (fill_valid) begin
            write_valid = 1'b1;
            write_set.entries[fill_way] = '{
                valid:           1'b1,
                asid:            stage_asid,
                vpn:             stage_vpn,
                ppn1:            l2_tlb_resp_pte.ppn1,
                ppn0:            l2_tlb_resp_pte.ppn0,
                g:               l2_tlb_resp_pte.g,
                u:               l2_tlb_resp_pte.u,
                x:               l2_tlb_resp_pte.x,
                w:               l2_tlb_resp_pte.w,
                r:               l2_tlb_resp_pte.r,
                v:               l2_tlb_resp_pte.v,
                pt_access_fault: l2_tlb_resp_access_fault
            };
        end else if (inv_active) begin
            write_valid = 1'b1;
            for (int w = 0; w < `ITLB_ASSOC; w++) begin
                if (hit_by_way[w]) begin
                    write_set.entries[w].valid = 1'b0;
                end
            end
        end else if (stage_valid & hit) begin
            write_valid    = 1'b1;
            write_set.plru = touch_plru;
        end
    end

endmodule

//--- hdl/itlb_set_array.sv
// register storage of the TLB sets with a registered read port and write-to-read forwarding
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_set_array import itlb_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     read_valid,
    input  logic [`ITLB_INDEX_W-1:0] read_index,
    input  logic                     write_valid,
    input  tlb_set_t                 write_set,
    output tlb_set_t                 read_set
);

    tlb_set_t [`ITLB_SETS-1:0] sets;
    logic [`ITLB_INDEX_W-1:0]  last_index;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            sets       <= '0;
            read_set   <= '0;
            last_index <= '0;
        end else begin
            // write back goes to the set now in the compare stage
            if (write_valid) begin
                sets[last_index] <= write_set;
            end

            if (read_valid) begin
                last_index <= read_index;
                // same set being written this cycle, take the new copy
                if (write_valid && (read_index == last_index)) begin
                    read_set <= write_set;
                end else begin
                    read_set <= sets[read_index];
                end
            end
        end
    end

endmodule

//--- hdl/itlb_lookup_ctrl.sv
// input side of the instruction TLB: request arbitration, set hash, sfence walk and stage registers
`timescale 1ns/1ps
`include "itlb_params.svh"

module itlb_lookup_ctrl import itlb_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,

    input  logic                     core_req_valid,
    input  exec_mode_e               core_req_exec_mode,
    input  logic [`ITLB_ASID_W-1:0]  core_req_asid,
    input  logic [`ITLB_VPN_W-1:0]   core_req_vpn,
    input  logic                     core_resp_valid,

    input  logic                     sfence_inv_valid,
    input  logic [`ITLB_ASID_W-1:0]  sfence_inv_asid,
    input  logic [`ITLB_VPN_W-1:0]   sfence_inv_vpn,
    output logic                     sfence_inv_ready,

    output logic                     read_valid,
    output logic [`ITLB_INDEX_W-1:0] read_index,

    output logic                     stage_valid,
    output exec_mode_e               stage_exec_mode,
    output logic [`ITLB_ASID_W-1:0]  stage_asid,
    output logic [`ITLB_VPN_W-1:0]   stage_vpn,
    output logic                     inv_active
);

    sfence_state_e            state;
    sfence_state_e            state_next;
    logic [`ITLB_INDEX_W-1:0] set_cnt;
    logic                     sf_accept;
    logic                     sf_all;
    logic                     core_accept;
    logic                     walk;
    logic [`ITLB_ASID_W-1:0]  sel_asid;
    logic [`ITLB_VPN_W-1:0]   sel_vpn;
    logic [`ITLB_INDEX_W-1:0] hash_index;

    // ------------------------------
    // arbitration

    // only the all-set walk blocks a new sfence
    assign sfence_inv_ready = (state != SF_INV_ALL);
    assign inv_active       = (state != SF_IDLE);

    assign sf_accept = sfence_inv_valid & sfence_inv_ready;
    assign sf_all    = sf_accept & (sfence_inv_vpn == '0);

    // skip the response cycle, the core still shows the answered request there
    assign core_accept = core_req_valid & ~sfence_inv_valid & sfence_inv_ready
                       & ~core_resp_valid;

    // sfence wins the read port
    assign sel_asid = sfence_inv_valid ? sfence_inv_asid : core_req_asid;
    assign sel_vpn  = sfence_inv_valid ? sfence_inv_vpn : core_req_vpn;

    // low VPN bits folded with low ASID bits
    assign hash_index = sel_vpn[`ITLB_INDEX_W-1:0]
                      ^ sel_vpn[2*`ITLB_INDEX_W-1:`ITLB_INDEX_W]
                      ^ sel_asid[`ITLB_INDEX_W-1:0]
                      ^ sel_asid[2*`ITLB_INDEX_W-1:`ITLB_INDEX_W];

    // counter drives the index for the whole VPN-zero walk
    assign walk       = sf_all | (state == SF_INV_ALL);
    assign read_valid = sf_accept | core_accept | walk;
    assign read_index = walk ? set_cnt : hash_index;

    // ------------------------------
    // sfence FSM

    always_comb begin
        state_next = state;
        case (state)
            SF_INV_ALL: begin
                // last set read, its invalidation follows as a single-set cycle
                if (set_cnt == (`ITLB_SETS - 1)) begin
                    state_next = SF_INV_SINGLE;
                end
            end
            default: begin
                if (sf_all) begin
                    state_next = SF_INV_ALL;
                end else if (sf_accept) begin
                    state_next = SF_INV_SINGLE;
                end else begin
                    state_next = SF_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state       <= SF_IDLE;
            set_cnt     <= '0;
            stage_valid <= 1'b0;
        end else begin
            state <= state_next;
            // wraps back to zero after the last set
            if (walk) begin
                set_cnt <= set_cnt + 1'b1;
            end
            stage_valid <= core_accept;
        end
    end

    // held through the walk so the wildcards stay applied
    always_ff @(posedge CLK) begin
        if (sf_accept | core_accept) begin
            stage_asid      <= sel_asid;
            stage_vpn       <= sel_vpn;
            stage_exec_mode <= core_req_exec_mode;
        end
    end

endmodule

//--- hdl/itlb_pkg.sv
// shared types of the instruction TLB, imported by the RTL modules and the testbench
`include "itlb_params.svh"

package itlb_pkg;

    // privilege of the fetching core
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } exec_mode_e;

    typedef enum logic [1:0] {
        SF_IDLE,
        SF_INV_SINGLE,
        SF_INV_ALL
    } sfence_state_e;

    // Sv32 leaf PTE as returned by the L2 TLB, msb first
    typedef struct packed {
        logic [`ITLB_PPN1_W-1:0] ppn1;
        logic [`ITLB_PPN0_W-1:0] ppn0;
        logic [1:0]              rsw;
        logic                    d;
        logic                    a;
        logic                    g;
        logic                    u;
        logic                    x;
        logic                    w;
        logic                    r;
        logic                    v;
    } pte_t;

    // one way of a set
    typedef struct packed {
        logic                    valid;
        logic [`ITLB_ASID_W-1:0] asid;
        logic [`ITLB_VPN_W-1:0]  vpn;
        logic [`ITLB_PPN1_W-1:0] ppn1;
        logic [`ITLB_PPN0_W-1:0] ppn0;
        logic                    g;
        logic                    u;
        logic                    x;
        logic                    w;
        logic                    r;
        logic                    v;
        logic                    pt_access_fault;
    } tlb_entry_t;

    typedef struct packed {
        tlb_entry_t [`ITLB_ASSOC-1:0] entries;
        logic [`ITLB_ASSOC-2:0]       plru;
    } tlb_set_t;

endpackage

//--- hdl/itlb_params.svh
// widths and array geometry of the instruction TLB, included by the package and every RTL file
`ifndef ITLB_PARAMS_SVH
`define ITLB_PARAMS_SVH

// Sv32 translation fields
`define ITLB_ASID_W  9
`define ITLB_VPN_W   20
`define ITLB_PPN_W   22
`define ITLB_PPN1_W  12
`define ITLB_PPN0_W  10

// ------------------------------
// 4 KB page array, 4 sets x 4 ways
`define ITLB_ASSOC   4
`define ITLB_WAY_W   2
`define ITLB_SETS    4
`define ITLB_INDEX_W 2

`endif
